/* sources.f */
hdl/vlsu_pkg.sv
hdl/vlsu_element_sequencer.sv
hdl/vlsu_access_formatter.sv
hdl/vlsu_data_memory.sv
hdl/vlsu_load_aligner.sv
hdl/vlsu_fence_tracker.sv
hdl/vlsu_top.sv
verification/vlsu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= vlsu_tb
RTL_TOP   ?= vlsu_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* verification/vlsu_tb.sv */
// Vector LSU testbench: byte-level reference memory, command runner, directed tests, timeout
module vlsu_tb
    import vlsu_pkg::*;
();

    localparam int MAX_VL          = 8;
    localparam int MEM_WORDS       = 64;
    localparam int MEM_BYTES       = 4 * MEM_WORDS;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 40;
    localparam int RESET_CYCLES    = 4;
    localparam int TIMEOUT_CYCLES  = NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES;

    logic               CLK;
    logic               nRST;
    logic               cmd_strobe;
    vec_cmd_t           cmd;
    word_t [MAX_VL-1:0] store_vector;
    logic               busy;
    logic               res_strobe;
    elem_idx_t          res_index;
    word_t              res_data;
    logic               res_fault;
    logic               fence;
    logic               icache_flush;
    logic               dcache_flush;
    logic               iflush_done;
    logic               dflush_done;
    logic               fence_stall;

    logic [7:0] model [MEM_BYTES];  // Expected memory contents, one entry per byte
    int         seed = 95;
    int         cycle_count = 0;
    string      test_name = "reset";

    vlsu_top #(.MAX_VL(MAX_VL), .MEM_WORDS(MEM_WORDS)) i_dut (.*);

    always #10 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: the run went past %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("Test failures found");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s %s: expected 0x%08h, actual 0x%08h", test_name, what, expected,
                     actual);
            $display("Test failures found");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge CLK);
        #1;  // Inputs change and outputs are sampled just after the edge
    endtask

    task automatic fill_random(input int count);
        for (int k = 0; k < count; k++) begin
            store_vector[k] = $random(seed);
        end
    endtask

    // Issues one command, then checks every result against the byte model at fixed latency
    task automatic run_cmd(input addr_t base, input addr_t stride, input int vl,
                           input elem_width_e width, input logic is_signed, input logic is_store);
        vec_cmd_t c;
        addr_t    a;
        int       size;
        word_t    exp_data;
        logic     exp_fault;
        c.base      = base;
        c.stride    = stride;
        c.vl        = 5'(vl);
        c.width     = width;
        c.is_signed = is_signed;
        c.is_store  = is_store;
        cmd         = c;
        cmd_strobe  = 1'b1;
        next_cycle();
        cmd_strobe  = 1'b0;
        for (int k = 0; k < 4; k++) begin
            check("busy while filling", 32'd1, 32'(busy));
            check("res_strobe before latency", 32'd0, 32'(res_strobe));
            next_cycle();
        end
        size = (width == EW_BYTE) ? 1 : (width == EW_HALF) ? 2 : 4;
        for (int i = 0; i < vl; i++) begin
            a         = base + addr_t'(i) * stride;
            exp_fault = (a & addr_t'(size - 1)) != 0;  // Natural alignment required
            exp_data  = '0;
            if (!exp_fault) begin
                for (int b = 0; b < size; b++) begin
                    if (is_store) begin
                        model[(a + addr_t'(b)) % MEM_BYTES] = store_vector[i][8*b +: 8];
                    end else begin
                        exp_data[8*b +: 8] = model[(a + addr_t'(b)) % MEM_BYTES];
                    end
                end
                if (!is_store && is_signed && exp_data[8*size-1]) begin
                    for (int b = size; b < 4; b++) begin
                        exp_data[8*b +: 8] = 8'hFF;
                    end
                end
            end
            check("res_strobe", 32'd1, 32'(res_strobe));
            check("res_index", 32'(i), 32'(res_index));
            check("res_fault", 32'(exp_fault), 32'(res_fault));
            check("res_data", exp_data, res_data);
            check("busy", 32'(i < vl - 1), 32'(busy));  // Low once the last result is out
            next_cycle();
        end
        check("res_strobe after last", 32'd0, 32'(res_strobe));
    endtask

    task automatic fence_round(input logic icache_first);
        fence = 1'b1;
        next_cycle();
        check("icache_flush pulse", 32'd1, 32'(icache_flush));
        check("dcache_flush pulse", 32'd1, 32'(dcache_flush));
        check("fence_stall at pulse", 32'd1, 32'(fence_stall));
        next_cycle();
        check("icache_flush width", 32'd0, 32'(icache_flush));
        check("dcache_flush width", 32'd0, 32'(dcache_flush));
        check("fence_stall waiting", 32'd1, 32'(fence_stall));
        iflush_done = icache_first;
        dflush_done = !icache_first;
        next_cycle();
        iflush_done = 1'b0;
        dflush_done = 1'b0;
        check("fence_stall after one done", 32'd1, 32'(fence_stall));
        next_cycle();
        check("fence_stall still waiting", 32'd1, 32'(fence_stall));
        iflush_done = !icache_first;
        dflush_done = icache_first;
        next_cycle();
        iflush_done = 1'b0;
        dflush_done = 1'b0;
        check("fence_stall after both done", 32'd0, 32'(fence_stall));
        repeat (2) begin
            next_cycle();
            check("no second pulse while held", 32'd0, 32'(icache_flush | dcache_flush));
        end
        fence = 1'b0;
        next_cycle();
    endtask

    initial begin
        CLK          = 1'b0;
        nRST         = 1'b0;
        cmd_strobe   = 1'b0;
        cmd          = '0;
        store_vector = '0;
        fence        = 1'b0;
        iflush_done  = 1'b0;
        dflush_done  = 1'b0;
        for (int k = 0; k < MEM_BYTES; k++) begin
            model[k] = 8'h00;
        end
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        nRST = 1'b1;
        check("busy", 32'd0, 32'(busy));
        check("res_strobe", 32'd0, 32'(res_strobe));
        check("fence_stall", 32'd0, 32'(fence_stall));

        test_name = "word_roundtrip";
        fill_random(8);
        run_cmd(32'h40, 32'd4, 8, EW_WORD, 1'b0, 1'b1);
        run_cmd(32'h40, 32'd4, 8, EW_WORD, 1'b0, 1'b0);

        test_name = "subword_loads";
        store_vector[0] = 32'h80FF_7F01;
        store_vector[1] = 32'h1234_8765;
        run_cmd(32'h00, 32'd4, 2, EW_WORD, 1'b0, 1'b1);
        run_cmd(32'h00, 32'd1, 8, EW_BYTE, 1'b1, 1'b0);
        run_cmd(32'h00, 32'd1, 8, EW_BYTE, 1'b0, 1'b0);
        run_cmd(32'h00, 32'd2, 4, EW_HALF, 1'b1, 1'b0);
        run_cmd(32'h00, 32'd2, 4, EW_HALF, 1'b0, 1'b0);

        test_name = "subword_stores";
        fill_random(4);
        run_cmd(32'h80, 32'd4, 4, EW_WORD, 1'b0, 1'b1);
        fill_random(4);
        run_cmd(32'h80, 32'd3, 4, EW_BYTE, 1'b0, 1'b1);
        run_cmd(32'h80, 32'd6, 3, EW_HALF, 1'b0, 1'b1);
        run_cmd(32'h80, 32'd4, 4, EW_WORD, 1'b0, 1'b0);

        test_name = "misaligned";
        fill_random(4);
        run_cmd(32'hC0, 32'd4, 4, EW_WORD, 1'b0, 1'b1);
        run_cmd(32'hC0, 32'd1, 4, EW_HALF, 1'b1, 1'b0);  // Odd elements fault
        run_cmd(32'hC2, 32'd2, 3, EW_WORD, 1'b0, 1'b0);
        fill_random(3);
        run_cmd(32'hC1, 32'd3, 3, EW_WORD, 1'b0, 1'b1);  // Only the middle element lands
        run_cmd(32'hC0, 32'd4, 4, EW_WORD, 1'b0, 1'b0);

        test_name = "negative_stride";
        fill_random(4);
        run_cmd(32'h20, 32'd4, 4, EW_WORD, 1'b0, 1'b1);
        run_cmd(32'h2C, -32'd4, 4, EW_WORD, 1'b0, 0);

        test_name = "fence";
        fence_round(1'b1);
        fence_round(1'b0);

        $display("All tests passed!");
        $finish;
    end

endmodule

/* hdl/vlsu_top.sv */
// Vector LSU top: four-stage element pipeline and fence tracker
module vlsu_top
    import vlsu_pkg::*;
#(
    parameter int MAX_VL    = 8,
    parameter int MEM_WORDS = 64
) (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               cmd_strobe,
    input  vec_cmd_t           cmd,
    input  word_t [MAX_VL-1:0] store_vector,
    output logic               busy,
    output logic               res_strobe,
    output elem_idx_t          res_index,
    output word_t              res_data,
    output logic               res_fault,
    input  logic               fence,
    output logic               icache_flush,
    output logic               dcache_flush,
    input  logic               iflush_done,
    input  logic               dflush_done,
    output logic               fence_stall
);

    logic      req_strobe;
    elem_req_t req;
    logic      mem_strobe;
    mem_req_t  mem_req;
    logic      rsp_strobe;
    mem_rsp_t  rsp;

    vlsu_element_sequencer #(.MAX_VL(MAX_VL)) i_sequencer (.*);

    vlsu_access_formatter i_formatter (.*);

    vlsu_data_memory #(.MEM_WORDS(MEM_WORDS)) i_memory (.*);

    vlsu_load_aligner i_aligner (.*);

    vlsu_fence_tracker i_fence (.*);

endmodule

/* hdl/vlsu_fence_tracker.sv */
// Fence tracker: fence edge detect, cache flush pulses and flush completion stall
module vlsu_fence_tracker (
    input  logic CLK,
    input  logic nRST,
    input  logic fence,
    input  logic iflush_done,
    input  logic dflush_done,
    output logic icache_flush,
    output logic dcache_flush,
    output logic fence_stall
);

    logic fence_q;
    logic flush_pulse;
    logic iflushed;  // Instruction cache has finished its last flush
    logic dflushed;  // Data cache has finished its last flush

    // Registered so both caches see a clean one-cycle pulse
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fence_q     <= 1'b0;
            flush_pulse <= 1'b0;
            iflushed    <= 1'b1;
            dflushed    <= 1'b1;
        end else begin
            fence_q     <= fence;
            flush_pulse <= fence && !fence_q;  // Rising edge only, a held fence gives one pulse
            if (iflush_done) begin
                iflushed <= 1'b1;
            end else if (flush_pulse) begin
                iflushed <= 1'b0;
            end
            if (dflush_done) begin
                dflushed <= 1'b1;
            end else if (flush_pulse) begin
                dflushed <= 1'b0;
            end
        end
    end

    assign icache_flush = flush_pulse;
    assign dcache_flush = flush_pulse;
    assign fence_stall  = fence_q && !(iflushed && dflushed) || flush_pulse;

    a_flush_after_completion: assert property (@(posedge CLK) disable iff (!nRST)
        icache_flush |-> iflushed && dflushed)
        else $error("New cache flush started before the previous flush completed");

endmodule

/* hdl/vlsu_load_aligner.sv */
// Load aligner: lane select, sign or zero extension, registered result with fault flag
module vlsu_load_aligner
    import vlsu_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    input  logic      rsp_strobe,
    input  mem_rsp_t  rsp,
    output logic      res_strobe,
    output elem_idx_t res_index,
    output word_t     res_data,
    output logic      res_fault
);

    word_t lane_word;
    word_t ext_word;

    // Lowest enabled lane moves down to bit 0
    always_comb begin
        case (rsp.byte_en)
            4'b0010:          lane_word = rsp.rdata >> 8;
            4'b0100, 4'b1100: lane_word = rsp.rdata >> 16;
            4'b1000:          lane_word = rsp.rdata >> 24;
            default:          lane_word = rsp.rdata;
        endcase
    end

    always_comb begin
        case (rsp.width)
            EW_BYTE: ext_word = {{24{rsp.is_signed & lane_word[7]}}, lane_word[7:0]};
            EW_HALF: ext_word = {{16{rsp.is_signed & lane_word[15]}}, lane_word[15:0]};
            default: ext_word = lane_word;
        endcase
        if (rsp.is_store || rsp.misaligned) begin
            ext_word = '0;  // No load data to report
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            res_strobe <= 1'b0;
        end else begin
            res_strobe <= rsp_strobe;
        end
    end

    always_ff @(posedge CLK) begin
        if (rsp_strobe) begin
            res_index <= rsp.index;
            res_data  <= ext_word;
            res_fault <= rsp.misaligned;
        end
    end

endmodule

/* hdl/vlsu_data_memory.sv */
// Data memory: word array with per-lane writes, registered read and tag forwarding
module vlsu_data_memory
    import vlsu_pkg::*;
#(
    parameter int MEM_WORDS = 64
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     mem_strobe,
    input  mem_req_t mem_req,
    output logic     rsp_strobe,
    output mem_rsp_t rsp
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    word_t            mem [MEM_WORDS];
    logic [IDX_W-1:0] word_idx;

    assign word_idx = IDX_W'(mem_req.word_addr[31:2] % MEM_WORDS);  // Addresses alias past the top

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem[w] <= '0;
            end
            rsp_strobe <= 1'b0;
        end else begin
            rsp_strobe <= mem_strobe;
            if (mem_strobe && mem_req.is_store) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem_req.byte_en[b]) begin
                        mem[word_idx][8*b +: 8] <= mem_req.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (mem_strobe) begin
            rsp.rdata      <= mem[word_idx];  // Read happens before any same-edge write
            rsp.byte_en    <= mem_req.byte_en;
            rsp.misaligned <= mem_req.misaligned;
            rsp.is_store   <= mem_req.is_store;
            rsp.index      <= mem_req.index;
            rsp.width      <= mem_req.width;
            rsp.is_signed  <= mem_req.is_signed;
        end
    end

endmodule

/* hdl/vlsu_access_formatter.sv */
// Access formatter: byte enables, store lane replication and misalignment flag, one register stage
module vlsu_access_formatter
    import vlsu_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    input  logic      req_strobe,
    input  elem_req_t req,
    output logic      mem_strobe,
    output mem_req_t  mem_req
);

    logic [1:0] offset;
    byte_en_t   lane_en;
    word_t      lane_data;
    logic       misaligned;

    assign offset = req.addr[1:0];

    always_comb begin
        lane_en    = '0;
        misaligned = 1'b0;
        case (req.width)
            EW_BYTE: lane_en = byte_en_t'(4'b0001 << offset);
            EW_HALF: begin
                misaligned = offset[0];  // Odd offset splits the halfword across lanes
                lane_en    = offset[1] ? 4'b1100 : 4'b0011;
            end
            EW_WORD: begin
                misaligned = (offset != 2'b00);
                lane_en    = 4'b1111;
            end
            default: misaligned = 1'b1;  // Unknown width is reported as a fault
        endcase
        if (misaligned) begin
            lane_en = '0;  // Never reaches the memory
        end
    end

    // Every lane holds a copy, so the enable alone picks the target bytes
    always_comb begin
        case (req.width)
            EW_BYTE: lane_data = {4{req.store_data[7:0]}};
            EW_HALF: lane_data = {2{req.store_data[15:0]}};
            default: lane_data = req.store_data;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mem_strobe <= 1'b0;
        end else begin
            mem_strobe <= req_strobe;
        end
    end

    always_ff @(posedge CLK) begin
        if (req_strobe) begin
            mem_req.word_addr  <= {req.addr[31:2], 2'b00};
            mem_req.byte_en    <= lane_en;
            mem_req.wdata      <= lane_data;
            mem_req.is_store   <= req.is_store;
            mem_req.misaligned <= misaligned;
            mem_req.index      <= req.index;
            mem_req.width      <= req.width;
            mem_req.is_signed  <= req.is_signed;
        end
    end

    a_known_width: assert property (@(posedge CLK) disable iff (!nRST)
        req_strobe |-> req.width inside {EW_BYTE, EW_HALF, EW_WORD})
        else $error("Element request arrived with an unknown width encoding");

endmodule

/* hdl/vlsu_element_sequencer.sv */
// Element sequencer: command and store operand latch, per-element address stepping, busy drain count
module vlsu_element_sequencer
    import vlsu_pkg::*;
#(
    parameter int MAX_VL = 8
) (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               cmd_strobe,
    input  vec_cmd_t           cmd,
    input  word_t [MAX_VL-1:0] store_vector,
    output logic               req_strobe,
    output elem_req_t          req,
    output logic               busy
);

    localparam int BUF_IDX_W = (MAX_VL > 1) ? $clog2(MAX_VL) : 1;

    seq_state_e         state;
    vec_cmd_t           cmd_q;
    word_t [MAX_VL-1:0] store_buf;
    addr_t              cur_addr;
    elem_idx_t          cur_idx;
    logic               last_elem;
    logic [1:0]         drain_cnt;  // Stages still holding the final element

    assign last_elem = (({1'b0, cur_idx} + 5'd1) == cmd_q.vl);
    assign busy = (state == SEQ_ISSUE) || (drain_cnt != 2'd0);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= SEQ_IDLE;
            req_strobe <= 1'b0;
            drain_cnt  <= 2'd0;
        end else begin
            req_strobe <= (state == SEQ_ISSUE);
            case (state)
                SEQ_IDLE:  state <= cmd_strobe ? SEQ_ISSUE : SEQ_IDLE;
                SEQ_ISSUE: state <= last_elem ? SEQ_IDLE : SEQ_ISSUE;
                default:   state <= SEQ_IDLE;
            endcase
            if (state == SEQ_ISSUE && last_elem) begin
                drain_cnt <= 2'd3;  // Formatter, memory and aligner each add one edge
            end else if (drain_cnt != 2'd0) begin
                drain_cnt <= drain_cnt - 2'd1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (state == SEQ_IDLE && cmd_strobe) begin
            cmd_q     <= cmd;
            store_buf <= store_vector;
            cur_addr  <= cmd.base;
            cur_idx   <= '0;
        end else if (state == SEQ_ISSUE) begin
            cur_addr <= cur_addr + cmd_q.stride;  // Wraps naturally for a negative stride
            cur_idx  <= cur_idx + 4'd1;
        end
        if (state == SEQ_ISSUE) begin
            req.addr       <= cur_addr;
            req.index      <= cur_idx;
            req.width      <= cmd_q.width;
            req.is_signed  <= cmd_q.is_signed;
            req.is_store   <= cmd_q.is_store;
            req.store_data <= store_buf[cur_idx[BUF_IDX_W-1:0]];  // Wraps past MAX_VL
        end
    end

    a_no_cmd_while_busy: assert property (@(posedge CLK) disable iff (!nRST)
        cmd_strobe |-> !busy)
        else $error("Vector command issued while the unit is busy");

endmodule

/* hdl/vlsu_pkg.sv */
// Vector LSU shared types: word, address, lane and index typedefs, width and sequencer enums, stage structs
package vlsu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  byte_en_t;  // One bit per byte lane, lane 0 is the least significant byte
    typedef logic [3:0]  elem_idx_t;  // Caps a command at 16 elements

    typedef enum logic [1:0] {
        EW_BYTE = 2'd0,
        EW_HALF = 2'd1,
        EW_WORD = 2'd2
    } elem_width_e;

    typedef enum logic {
        SEQ_IDLE  = 1'b0,
        SEQ_ISSUE = 1'b1
    } seq_state_e;

    typedef struct packed {
        addr_t                      base;
        addr_t                      stride;  // Byte stride in two's complement
        logic [$bits(elem_idx_t):0] vl;  // Element count from 1 to 16
        elem_width_e                width;
        logic                       is_signed;
        logic                       is_store;
    } vec_cmd_t;

    typedef struct packed {
        addr_t       addr;
        elem_idx_t   index;
        elem_width_e width;
        logic        is_signed;
        logic        is_store;
        word_t       store_data;
    } elem_req_t;

    typedef struct packed {
        addr_t       word_addr;  // Byte offset bits are always zero
        byte_en_t    byte_en;
        word_t       wdata;
        logic        is_store;
        logic        misaligned;
        elem_idx_t   index;
        elem_width_e width;
        logic        is_signed;
    } mem_req_t;

    typedef struct packed {
        word_t       rdata;
        byte_en_t    byte_en;
        logic        misaligned;
        logic        is_store;
        elem_idx_t   index;
        elem_width_e width;
        logic        is_signed;
    } mem_rsp_t;

endpackage
